// File: logic/ifu_defines.svh
// Fetch unit sizing macros
// Address and instruction width, parcel width
// Queue depth in words and parcels, transaction counter width

`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// Address and instruction width
`define IFU_XLEN        32
// One 16-bit instruction parcel
`define IFU_PARCEL_W    16
// Queue depth
`define IFU_Q_WORDS     2
`define IFU_Q_PARCELS   4
// Pending and discard counter width
`define IFU_TXN_CNT_W   3

`endif

// File: logic/ifu_mem_pkg.sv
// Instruction memory port types
// Response kind, byte address, read data word
// Transaction count for pending and discarded requests

package ifu_mem_pkg;

`include "ifu_defines.svh"

// Response codes, one per accepted request
typedef enum logic [1:0] {
    MEM_RESP_IDLE   = 2'b00,  // Nothing this cycle
    MEM_RESP_RDY_OK = 2'b01,  // Read data valid
    MEM_RESP_RDY_ER = 2'b10   // Access fault
} mem_resp_e;

// Byte address, low two bits zero on requests
typedef logic [`IFU_XLEN-1:0]      imem_addr_t;

typedef logic [`IFU_XLEN-1:0]      imem_word_t;   // Read data

typedef logic [`IFU_TXN_CNT_W-1:0] txn_cnt_t;     // In-flight count

endpackage : ifu_mem_pkg

// File: logic/ifu_instr_pkg.sv
// Instruction side types
// Parcel and instruction words, free queue word count
// Classification of a returned word, queue write size

package ifu_instr_pkg;

`include "ifu_defines.svh"

typedef logic [`IFU_PARCEL_W-1:0]          parcel_t;   // One halfword
typedef logic [`IFU_XLEN-1:0]              instr_t;    // RVC zero-extended
typedef logic [$clog2(`IFU_Q_WORDS+1)-1:0] q_free_t;   // 0..2 words

// Word content, named <upper half>_<lower half>
typedef enum logic [2:0] {
    KIND_NONE,           // Nothing to write
    KIND_RVI_HI_RVI_LO,  // One full RVI
    KIND_RVC_RVC,
    KIND_RVI_LO_RVC,     // RVC, then start of an RVI
    KIND_RVC_RVI_HI,     // End of a split RVI, then RVC
    KIND_RVI_LO_RVI_HI,  // End of a split RVI, then start of next
    KIND_RVC_NV,         // Unaligned new PC, lower half unused
    KIND_RVI_LO_NV       // Unaligned new PC, RVI starts in upper half
} fetch_kind_e;

// How many parcels a response puts in the queue
typedef enum logic [1:0] {
    Q_WR_NONE,
    Q_WR_FULL,           // Both halves
    Q_WR_HI              // Upper half only
} q_wr_e;

endpackage : ifu_instr_pkg

// File: logic/ifu_imem_ctrl.sv
// Request side of the fetch unit
// Idle/fetch FSM and word address register
// Pending request counter and response discard counter

`timescale 1ns/1ps

`include "ifu_defines.svh"

module ifu_imem_ctrl
    import ifu_mem_pkg::*;
    import ifu_instr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pc_new_req_i,    // Redirect from execute
    input  imem_addr_t pc_new_i,
    input  logic       stop_fetch_i,
    input  logic       imem_ack_i,
    input  mem_resp_e  imem_resp_i,
    input  q_free_t    free_words_i,    // Free words after this cycle's pop
    output logic       imem_req_o,
    output imem_addr_t imem_addr_o,
    output logic       resp_vd_o,       // Response goes to the queue
    output logic       resp_er_o        // ... and it is a fault
);

typedef enum logic {
    FSM_IDLE,
    FSM_FETCH
} fsm_e;

fsm_e                 fsm_ff;
fsm_e                 fsm_next;
logic                 fetch_start;
logic                 fetch_stop;

logic                 resp_ok;
logic                 resp_er;
logic                 resp_rcvd;
logic                 hs_done;

logic [`IFU_XLEN-1:2] addr_ff;          // Word address of next request
logic [`IFU_XLEN-1:2] addr_next;

txn_cnt_t             pnd_cnt;
txn_cnt_t             pnd_cnt_next;
logic                 pnd_full;
txn_cnt_t             dsc_cnt;
txn_cnt_t             dsc_cnt_next;
logic                 dsc_cnt_upd;
logic                 dsc_reload;
logic                 dsc_req;
txn_cnt_t             vd_pnd_cnt;
logic                 has_room;

//----------------------------------------
// Responses
//----------------------------------------

assign resp_ok   = (imem_resp_i == MEM_RESP_RDY_OK);
assign resp_er   = (imem_resp_i == MEM_RESP_RDY_ER);
assign resp_rcvd = resp_ok | resp_er;
assign dsc_req   = |dsc_cnt;                // Still old-stream responses out there
assign resp_vd_o = resp_rcvd & ~dsc_req;
assign resp_er_o = resp_er & ~dsc_req;
assign hs_done   = imem_req_o & imem_ack_i;

//----------------------------------------
// FSM
//----------------------------------------

assign fetch_start = pc_new_req_i & ~stop_fetch_i;
assign fetch_stop  = stop_fetch_i | (resp_er_o & ~pc_new_req_i);  // Fault ends the stream

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        fsm_ff <= FSM_IDLE;
    end else begin
        fsm_ff <= fsm_next;
    end
end

always_comb begin
    case (fsm_ff)
        FSM_IDLE: fsm_next = fetch_start ? FSM_FETCH : FSM_IDLE;
        default:  fsm_next = fetch_stop  ? FSM_IDLE  : FSM_FETCH;
    endcase
end

// Word address, steps on every accepted request
always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        addr_ff <= '0;
    end else if (pc_new_req_i | hs_done) begin
        addr_ff <= addr_next;
    end
end

assign addr_next = (pc_new_req_i ? pc_new_i[`IFU_XLEN-1:2] : addr_ff)
                 + (`IFU_XLEN-2)'(hs_done);

//----------------------------------------
// Transaction counters
//----------------------------------------

assign pnd_cnt_next = pnd_cnt + txn_cnt_t'(hs_done) - txn_cnt_t'(resp_rcvd);
assign pnd_full     = &pnd_cnt;

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        pnd_cnt <= '0;
    end else begin
        pnd_cnt <= pnd_cnt_next;
    end
end

// Redirect or stop drops all in flight except this cycle's new request
assign dsc_reload   = pc_new_req_i | stop_fetch_i;
assign dsc_cnt_upd  = dsc_reload | resp_er_o | (resp_rcvd & dsc_req);
assign dsc_cnt_next = dsc_reload ? pnd_cnt_next - txn_cnt_t'(hs_done)
                    : resp_er_o  ? pnd_cnt_next     // Nothing after a fault is trusted
                                 : dsc_cnt - txn_cnt_t'(1);

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        dsc_cnt <= '0;
    end else if (dsc_cnt_upd) begin
        dsc_cnt <= dsc_cnt_next;
    end
end

assign vd_pnd_cnt = pnd_cnt - dsc_cnt;                      // Responses that will be kept
assign has_room   = txn_cnt_t'(free_words_i) > vd_pnd_cnt;  // Queue never overflows

//----------------------------------------
// Request outputs
//----------------------------------------

assign imem_req_o  = ~stop_fetch_i & ~pnd_full
                   & (pc_new_req_i | ((fsm_ff == FSM_FETCH) & has_room));
assign imem_addr_o = pc_new_req_i ? {pc_new_i[`IFU_XLEN-1:2], 2'b00}
                                  : {addr_ff, 2'b00};

endmodule : ifu_imem_ctrl

// File: logic/ifu_parcel_queue.sv
// Four-parcel instruction queue
// Unaligned-start and split-RVI tracking, word classification
// Parcel and fault storage, pointers, occupancy and free words

`timescale 1ns/1ps

`include "ifu_defines.svh"

module ifu_parcel_queue
    import ifu_mem_pkg::*;
    import ifu_instr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pc_new_req_i,
    input  logic       pc_new_unaligned_i,  // Bit 1 of new PC
    input  logic       stop_fetch_i,
    input  logic       resp_vd_i,
    input  logic       resp_er_i,
    input  imem_word_t rdata_i,
    input  logic       pop_hword_i,
    input  logic       pop_word_i,
    output parcel_t    head_o,
    output parcel_t    next_o,
    output logic       head_err_o,
    output logic       next_err_o,
    output logic       empty_o,
    output logic       one_parcel_o,
    output q_free_t    free_words_o
);

localparam int ADR_W  = $clog2(`IFU_Q_PARCELS);
localparam int PTR_W  = ADR_W + 1;              // Extra wrap bit
localparam int FREE_W = $clog2(`IFU_Q_PARCELS + 1);

logic              unaligned_ff;    // Next word starts in its upper half
logic              rvi_lo_ff;       // Last word ended with low half of an RVI
logic              hi_is_rvi;
logic              lo_is_rvi;
parcel_t           rdata_lo;
parcel_t           rdata_hi;
fetch_kind_e       kind;
q_wr_e             wr_size;

logic              flush;
logic              drop;
logic [PTR_W-1:0]  wptr;
logic [PTR_W-1:0]  wptr_next;
logic [PTR_W-1:0]  rptr;
logic [PTR_W-1:0]  rptr_next;
logic [ADR_W-1:0]  wa_lo;
logic [ADR_W-1:0]  wa_hi;
parcel_t           q_data [`IFU_Q_PARCELS];
logic              q_err  [`IFU_Q_PARCELS];
logic [PTR_W-1:0]  ocpd;
logic [PTR_W-1:0]  ocpd_next;
logic [FREE_W-1:0] free_h_next;

assign rdata_lo  = rdata_i[`IFU_PARCEL_W-1:0];
assign rdata_hi  = rdata_i[2*`IFU_PARCEL_W-1:`IFU_PARCEL_W];
assign hi_is_rvi = &rdata_hi[1:0];
assign lo_is_rvi = &rdata_lo[1:0];

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        unaligned_ff <= 1'b0;
        rvi_lo_ff    <= 1'b0;
    end else if (pc_new_req_i) begin
        unaligned_ff <= pc_new_unaligned_i;
        rvi_lo_ff    <= 1'b0;
    end else if (resp_vd_i) begin
        unaligned_ff <= 1'b0;                   // Only the first word is affected
        rvi_lo_ff    <= (kind == KIND_RVI_LO_NV) | (kind == KIND_RVI_LO_RVI_HI)
                      | (kind == KIND_RVI_LO_RVC);
    end
end

//----------------------------------------
// Word classification
//----------------------------------------

always_comb begin
    kind = KIND_NONE;
    if (resp_vd_i & ~resp_er_i) begin
        if (unaligned_ff) begin
            kind = hi_is_rvi ? KIND_RVI_LO_NV : KIND_RVC_NV;
        end else if (rvi_lo_ff) begin
            kind = hi_is_rvi ? KIND_RVI_LO_RVI_HI : KIND_RVC_RVI_HI;
        end else begin
            case ({hi_is_rvi, lo_is_rvi})
                2'b00:   kind = KIND_RVC_RVC;
                2'b10:   kind = KIND_RVI_LO_RVC;
                default: kind = KIND_RVI_HI_RVI_LO;  // Low half starts an RVI
            endcase
        end
    end
end

always_comb begin
    wr_size = Q_WR_NONE;
    if (resp_vd_i & resp_er_i) begin
        wr_size = Q_WR_FULL;                    // Both halves marked faulty
    end else begin
        case (kind)
            KIND_NONE:      wr_size = Q_WR_NONE;
            KIND_RVC_NV,
            KIND_RVI_LO_NV: wr_size = Q_WR_HI;
            default:        wr_size = Q_WR_FULL;
        endcase
    end
end

//----------------------------------------
// Pointers and storage
//----------------------------------------

assign flush = pc_new_req_i | stop_fetch_i;
// Popping a fault drops the rest of the failed stream
assign drop  = (head_err_o & (pop_hword_i | pop_word_i)) | (next_err_o & pop_word_i);

assign wptr_next = flush                 ? '0
                 : (wr_size == Q_WR_FULL) ? wptr + PTR_W'(2)
                 : (wr_size == Q_WR_HI)   ? wptr + PTR_W'(1)
                                          : wptr;

always_comb begin
    rptr_next = rptr;
    if (flush) begin
        rptr_next = '0;
    end else if (drop) begin
        rptr_next = wptr;
    end else if (pop_word_i) begin
        rptr_next = rptr + PTR_W'(2);
    end else if (pop_hword_i) begin
        rptr_next = rptr + PTR_W'(1);
    end
end

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        wptr <= '0;
        rptr <= '0;
    end else begin
        wptr <= wptr_next;
        rptr <= rptr_next;
    end
end

assign wa_lo = ADR_W'(wptr);
assign wa_hi = ADR_W'(wptr + PTR_W'(1));

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        q_data <= '{default: '0};
        q_err  <= '{default: 1'b0};
    end else if (resp_vd_i & ~flush) begin
        case (wr_size)
            Q_WR_HI: begin
                q_data[wa_lo] <= rdata_hi;
                q_err[wa_lo]  <= resp_er_i;
            end
            Q_WR_FULL: begin
                q_data[wa_lo] <= rdata_lo;
                q_err[wa_lo]  <= resp_er_i;
                q_data[wa_hi] <= rdata_hi;
                q_err[wa_hi]  <= resp_er_i;
            end
            default: begin
            end
        endcase
    end
end

// Status toward decode and request side
assign head_o       = q_data[ADR_W'(rptr)];
assign next_o       = q_data[ADR_W'(rptr + PTR_W'(1))];
assign head_err_o   = q_err[ADR_W'(rptr)];
assign next_err_o   = q_err[ADR_W'(rptr + PTR_W'(1))];
assign ocpd         = wptr - rptr;
assign empty_o      = (rptr == wptr);
assign one_parcel_o = (ocpd == PTR_W'(1));
assign ocpd_next    = wptr - rptr_next;           // After this cycle's pop
assign free_h_next  = FREE_W'(`IFU_Q_PARCELS) - FREE_W'(ocpd_next);
assign free_words_o = q_free_t'(free_h_next >> 1);

endmodule : ifu_parcel_queue

// File: logic/ifu_idu_out.sv
// Decode side of the fetch unit
// RVC/RVI assembly from queue head, fault flags, pop size

`timescale 1ns/1ps

module ifu_idu_out
    import ifu_instr_pkg::*;
(
    input  logic    idu_rdy_i,
    input  parcel_t head_i,
    input  parcel_t next_i,
    input  logic    head_err_i,
    input  logic    next_err_i,
    input  logic    empty_i,
    input  logic    one_parcel_i,
    output instr_t  idu_instr_o,
    output logic    idu_vd_o,
    output logic    idu_err_o,
    output logic    idu_err_rvi_hi_o,     // Fault on upper half of an RVI
    output logic    pop_hword_o,
    output logic    pop_word_o
);

logic head_is_rvi;
logic take_hword;
logic rd_vd;

assign head_is_rvi = &head_i[1:0];        // Low bits 11 mean 32-bit

always_comb begin
    idu_vd_o         = 1'b0;
    idu_err_o        = 1'b0;
    idu_err_rvi_hi_o = 1'b0;
    if (~empty_i) begin
        if (one_parcel_i) begin
            idu_vd_o  = ~head_is_rvi | head_err_i;  // RVI waits for its upper parcel
            idu_err_o = head_err_i;
        end else begin
            idu_vd_o         = 1'b1;
            idu_err_o        = head_err_i | (head_is_rvi & next_err_i);
            idu_err_rvi_hi_o = ~head_err_i & head_is_rvi & next_err_i;
        end
    end
end

assign idu_instr_o = head_is_rvi ? {next_i, head_i} : instr_t'(head_i);

// Faulty head goes out alone
assign take_hword  = ~head_is_rvi | head_err_i;
assign rd_vd       = idu_vd_o & idu_rdy_i;
assign pop_hword_o = rd_vd & take_hword;
assign pop_word_o  = rd_vd & ~take_hword;

endmodule : ifu_idu_out

// File: logic/ifu_top.sv
// Instruction fetch unit top level
// Request control, parcel queue and decode output stage

`timescale 1ns/1ps

module ifu_top
    import ifu_mem_pkg::*;
    import ifu_instr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pc_new_req_i,
    input  imem_addr_t pc_new_i,
    input  logic       stop_fetch_i,
    input  logic       imem_ack_i,
    input  imem_word_t imem_rdata_i,
    input  mem_resp_e  imem_resp_i,
    input  logic       idu_rdy_i,
    output logic       imem_req_o,
    output imem_addr_t imem_addr_o,
    output instr_t     idu_instr_o,
    output logic       idu_vd_o,
    output logic       idu_err_o,
    output logic       idu_err_rvi_hi_o
);

logic    resp_vd;
logic    resp_er;
q_free_t free_words;
parcel_t q_head;
parcel_t q_next;
logic    q_head_err;
logic    q_next_err;
logic    q_empty;
logic    q_one_parcel;
logic    pop_hword;
logic    pop_word;

ifu_imem_ctrl u_imem_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_new_req_i (pc_new_req_i),
    .pc_new_i     (pc_new_i),
    .stop_fetch_i (stop_fetch_i),
    .imem_ack_i   (imem_ack_i),
    .imem_resp_i  (imem_resp_i),
    .free_words_i (free_words),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .resp_vd_o    (resp_vd),
    .resp_er_o    (resp_er)
);

ifu_parcel_queue u_parcel_queue (
    .clk                (clk),
    .rst_n              (rst_n),
    .pc_new_req_i       (pc_new_req_i),
    .pc_new_unaligned_i (pc_new_i[1]),   // Halfword start
    .stop_fetch_i       (stop_fetch_i),
    .resp_vd_i          (resp_vd),
    .resp_er_i          (resp_er),
    .rdata_i            (imem_rdata_i),
    .pop_hword_i        (pop_hword),
    .pop_word_i         (pop_word),
    .head_o             (q_head),
    .next_o             (q_next),
    .head_err_o         (q_head_err),
    .next_err_o         (q_next_err),
    .empty_o            (q_empty),
    .one_parcel_o       (q_one_parcel),
    .free_words_o       (free_words)
);

ifu_idu_out u_idu_out (
    .idu_rdy_i        (idu_rdy_i),
    .head_i           (q_head),
    .next_i           (q_next),
    .head_err_i       (q_head_err),
    .next_err_i       (q_next_err),
    .empty_i          (q_empty),
    .one_parcel_i     (q_one_parcel),
    .idu_instr_o      (idu_instr_o),
    .idu_vd_o         (idu_vd_o),
    .idu_err_o        (idu_err_o),
    .idu_err_rvi_hi_o (idu_err_rvi_hi_o),
    .pop_hword_o      (pop_hword),
    .pop_word_o       (pop_word)
);

endmodule : ifu_top

// File: tests/ifu_assertions.sv
// Concurrent checks on the fetch unit ports
// Word-aligned requests, no unknown outputs, fault flag ordering

`timescale 1ns/1ps

module ifu_assertions
    import ifu_mem_pkg::*;
    import ifu_instr_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       imem_req_o,
    input imem_addr_t imem_addr_o,
    input instr_t     idu_instr_o,
    input logic       idu_vd_o,
    input logic       idu_err_o,
    input logic       idu_err_rvi_hi_o
);

int fail_cnt = 0;   // Failed assertion count

// Requests always target a whole word
req_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_o |-> (imem_addr_o[1:0] == 2'b00))
    else begin
        fail_cnt++;
        $error("request address is not word aligned");
    end

// Control outputs known once out of reset
ctrl_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({imem_req_o, idu_vd_o, idu_err_o, idu_err_rvi_hi_o}))
    else begin
        fail_cnt++;
        $error("unknown value on a control output");
    end

addr_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_o |-> !$isunknown(imem_addr_o))   // Address only matters with req
    else begin
        fail_cnt++;
        $error("unknown request address");
    end

instr_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    idu_vd_o |-> !$isunknown(idu_instr_o))
    else begin
        fail_cnt++;
        $error("unknown instruction while valid");
    end

// Upper-half fault is a kind of fault
err_hi_a: assert property (@(posedge clk) disable iff (!rst_n)
    idu_err_rvi_hi_o |-> idu_err_o)
    else begin
        fail_cnt++;
        $error("upper-half fault flag without fault flag");
    end

endmodule : ifu_assertions

bind ifu_top ifu_assertions u_assertions (.*);

// File: tests/ifu_tb.sv
// Testbench for the instruction fetch unit
// Clock, reset, instruction memory model with random ack and latency
// Reference walk of memory, transfer compare, timeout and report

`timescale 1ns/1ps

`include "ifu_defines.svh"

module ifu_tb
    import ifu_mem_pkg::*;
    import ifu_instr_pkg::*;
();

localparam int CLK_HALF    = 10;                  // 20 ns period
localparam int MEM_WORDS   = 64;                  // Addresses wrap at 256 bytes
localparam int MAX_INSTR   = 110;                 // Sum of all stream lengths
localparam int CYCLE_LIMIT = 35 * MAX_INSTR + 150;  // 4000 cycles including idle gaps

logic       clk;
logic       rst_n;
logic       pc_new_req_i;
imem_addr_t pc_new_i;
logic       stop_fetch_i;
logic       imem_ack_i;
imem_word_t imem_rdata_i;
mem_resp_e  imem_resp_i;
logic       idu_rdy_i;
logic       imem_req_o;
imem_addr_t imem_addr_o;
instr_t     idu_instr_o;
logic       idu_vd_o;
logic       idu_err_o;
logic       idu_err_rvi_hi_o;

imem_word_t mem      [MEM_WORDS];
logic       bad_word [MEM_WORDS];               // Words answered with a fault
imem_addr_t rsp_addr_q [$];                     // Accepted and not yet answered
int         rsp_due_q  [$];
int         last_due;

instr_t     exp_instr_q  [$];
logic       exp_err_q    [$];
logic       exp_err_hi_q [$];
int         cycle;
int         got;                                // Transfers seen
int         target;                             // Transfers expected so far
int         mismatch_cnt;
int         other_cnt;
int         stop_req_cnt;
logic       expect_idle;
string      test_name;

initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
end

ifu_top UUT (.*);

//----------------------------------------
// Reference model
//----------------------------------------

function automatic int word_idx(input imem_addr_t addr);
    return int'(addr >> 2) % MEM_WORDS;
endfunction

function automatic parcel_t half_at(input imem_addr_t addr);
    imem_word_t w;
    w = mem[word_idx(addr)];
    return addr[1] ? w[2*`IFU_PARCEL_W-1:`IFU_PARCEL_W] : w[`IFU_PARCEL_W-1:0];
endfunction

// Expected instruction at pc and its length in bytes
function automatic int ref_instr(input imem_addr_t pc, output instr_t instr,
                                 output logic err, output logic err_hi);
    parcel_t lo;
    parcel_t hi;
    logic    is_rvi;
    lo     = half_at(pc);
    hi     = half_at(pc + 2);
    is_rvi = (lo[1:0] == 2'b11);                // Otherwise compressed
    instr  = is_rvi ? {hi, lo} : instr_t'(lo);
    err    = bad_word[word_idx(pc)];
    err_hi = 1'b0;
    if (!err && is_rvi && bad_word[word_idx(pc + 2)]) begin
        err    = 1'b1;                          // Upper half lives in a faulty word
        err_hi = 1'b1;
    end
    return is_rvi ? 4 : 2;
endfunction

function automatic parcel_t rand_parcel();
    parcel_t p;
    p = parcel_t'($urandom);
    if (($urandom % 5) < 2) begin
        p[1:0] = 2'b11;                         // About 40 % RVI
    end else begin
        p[1:0] = 2'($urandom % 3);
    end
    return p;
endfunction

// Walk memory from pc until n instructions or the first fault
task automatic queue_expected(input imem_addr_t pc, input int n);
    instr_t     instr;
    logic       err;
    logic       err_hi;
    imem_addr_t addr;
    int         len;
    addr = pc;
    for (int i = 0; i < n; i++) begin
        len = ref_instr(addr, instr, err, err_hi);
        exp_instr_q.push_back(instr);
        exp_err_q.push_back(err);
        exp_err_hi_q.push_back(err_hi);
        target++;
        if (err) begin
            break;
        end
        addr = addr + imem_addr_t'(len);
    end
endtask

//----------------------------------------
// Compare tasks
//----------------------------------------

task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (exp !== act) begin
        mismatch_cnt++;
        $display("mismatch %s instr: expected %08h actual %08h", name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        mismatch_cnt++;
        $display("mismatch %s: expected %b actual %b", name, exp, act);
    end
endtask

task automatic check_addr(input string name, input imem_addr_t exp, input imem_addr_t act);
    if (exp !== act) begin
        mismatch_cnt++;
        $display("mismatch %s addr: expected %08h actual %08h", name, exp, act);
    end
endtask

//----------------------------------------
// Memory model
//----------------------------------------

// Answers in order one per cycle with due time set at acceptance
always @(negedge clk) begin
    imem_addr_t addr;
    imem_resp_i = MEM_RESP_IDLE;
    imem_ack_i  = ($urandom % 3) != 0;
    if (rsp_addr_q.size() != 0 && rsp_due_q[0] <= cycle) begin
        addr = rsp_addr_q.pop_front();
        void'(rsp_due_q.pop_front());
        imem_rdata_i = mem[word_idx(addr)];
        imem_resp_i  = bad_word[word_idx(addr)] ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
    end
end

//----------------------------------------
// Monitor just before each rising edge
//----------------------------------------

always begin
    int     due;
    instr_t e_instr;
    logic   e_err;
    logic   e_hi;
    @(negedge clk);
    #(CLK_HALF - 1);
    cycle++;
    if (rst_n) begin
        if (imem_req_o & imem_ack_i) begin
            due = cycle + int'($urandom % 3);           // 1 to 3 cycles later
            if (due <= last_due) begin
                due = last_due + 1;                     // Keep order
            end
            last_due = due;
            rsp_addr_q.push_back(imem_addr_o);
            rsp_due_q.push_back(due);
        end
        if (stop_fetch_i & imem_req_o) begin
            stop_req_cnt++;
            $display("%s: request issued while stop is high", test_name);
        end
        if (pc_new_req_i & imem_req_o) begin
            check_addr(test_name, pc_new_i & ~imem_addr_t'(3), imem_addr_o);
        end
        if (expect_idle & (imem_req_o | idu_vd_o)) begin
            other_cnt++;
            $display("%s: request or valid seen while fetch should be idle", test_name);
        end
        if (idu_vd_o & idu_rdy_i) begin
            if (exp_instr_q.size() == 0) begin
                other_cnt++;
                $display("%s: decode transfer with no instruction expected", test_name);
            end else begin
                e_instr = exp_instr_q.pop_front();
                e_err   = exp_err_q.pop_front();
                e_hi    = exp_err_hi_q.pop_front();
                check_flag({test_name, " err"}, e_err, idu_err_o);
                check_flag({test_name, " err_rvi_hi"}, e_hi, idu_err_rvi_hi_o);
                if (!e_err) begin
                    check_instr(test_name, e_instr, idu_instr_o);
                end
                got++;
            end
        end
    end
end

initial begin
    wait (cycle >= CYCLE_LIMIT);
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAIL");
    $finish;
end

//----------------------------------------
// Stimulus
//----------------------------------------

// Redirect to pc and take n instructions under random ready
task automatic run_stream(input string name, input imem_addr_t pc, input int n);
    test_name = name;
    queue_expected(pc, n);
    pc_new_req_i = 1'b1;
    pc_new_i     = pc;
    idu_rdy_i    = 1'b0;
    @(negedge clk);
    pc_new_req_i = 1'b0;
    while (got < target) begin
        idu_rdy_i = ($urandom % 4) != 0;
        @(negedge clk);
    end
    idu_rdy_i = 1'b0;                           // Nothing more may move
endtask

// Decode ready while nothing may be requested or valid
task automatic hold_idle(input int ncyc);
    idu_rdy_i   = 1'b1;
    expect_idle = 1'b1;
    repeat (ncyc) @(negedge clk);
    expect_idle = 1'b0;
    idu_rdy_i   = 1'b0;
endtask

initial begin
    void'($urandom(32'h3826));
    rst_n        = 1'b0;
    pc_new_req_i = 1'b0;
    pc_new_i     = '0;
    stop_fetch_i = 1'b0;
    imem_ack_i   = 1'b0;
    imem_rdata_i = '0;
    imem_resp_i  = MEM_RESP_IDLE;
    idu_rdy_i    = 1'b0;
    cycle        = 0;
    got          = 0;
    target       = 0;
    last_due     = -1;
    mismatch_cnt = 0;
    other_cnt    = 0;
    stop_req_cnt = 0;
    expect_idle  = 1'b0;
    test_name    = "reset";
    for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i]      = {rand_parcel(), rand_parcel()};
        bad_word[i] = 1'b0;
    end
    mem[8][17:16]  = 2'b11;                     // RVI starts in upper half
    mem[43][17:16] = 2'b11;                     // Split RVI into faulty word 44
    bad_word[44]   = 1'b1;
    bad_word[52]   = 1'b1;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    run_stream("aligned_mix", 32'h0000_0000, 40);
    run_stream("unaligned_start", 32'h0000_0022, 10);   // Upper half of word 8
    run_stream("redirect_old", 32'h0000_0040, 6);
    run_stream("redirect_new", 32'h0000_000A, 10);      // Old responses still in flight
    run_stream("fault_rvi_hi", 32'h0000_00AE, 4);
    hold_idle(10);
    run_stream("fault_walk", 32'h0000_00C0, 20);        // Runs into word 52
    hold_idle(10);
    run_stream("fault_head", 32'h0000_00D0, 4);
    hold_idle(10);
    run_stream("stop_before", 32'h0000_0060, 8);
    test_name    = "stop";
    stop_fetch_i = 1'b1;
    @(negedge clk);
    stop_fetch_i = 1'b0;
    hold_idle(8);
    run_stream("stop_resume", 32'h0000_007A, 8);
    repeat (4) @(negedge clk);

    $display("errors: mismatch %0d, other %0d, stop requests %0d, assertions %0d",
             mismatch_cnt, other_cnt, stop_req_cnt, UUT.u_assertions.fail_cnt);
    if (mismatch_cnt + other_cnt + stop_req_cnt + UUT.u_assertions.fail_cnt == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

endmodule : ifu_tb

// File: all.f
+incdir+logic
logic/ifu_mem_pkg.sv
logic/ifu_instr_pkg.sv
logic/ifu_imem_ctrl.sv
logic/ifu_parcel_queue.sv
logic/ifu_idu_out.sv
logic/ifu_top.sv
tests/ifu_assertions.sv
tests/ifu_tb.sv

// File: Bender.yml
package:
  name: ifu

sources:
  - include_dirs:
      - logic
    files:
      - logic/ifu_mem_pkg.sv
      - logic/ifu_instr_pkg.sv
      - logic/ifu_imem_ctrl.sv
      - logic/ifu_parcel_queue.sv
      - logic/ifu_idu_out.sv
      - logic/ifu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/ifu_assertions.sv
      - tests/ifu_tb.sv
